// File: logic/dsp_pio_pkg.sv
// shared definitions for the parallel I/O unit of the DSP core
// word type, register address codes and the control-register layout
// every RTL file refers to these by scoped name
package dsp_pio_pkg;

    // data path width of the core
    localparam int pio_w = 16;

    typedef logic [pio_w-1:0] pio_word_t;

    // register select as carried on the CPU r_field
    // code 3 is not assigned and behaves as data register 1
    typedef enum logic [1:0] {
        pioc_addr = 2'd0,
        pdx0_addr = 2'd1,
        pdx1_addr = 2'd2
    } pio_addr_e;

    // control word, msb first
    typedef struct packed {
        // mirrors status bit 4 on a read
        logic       stat_copy;
        // strobe length, low time is stlen+1 enabled clocks
        logic [1:0] stlen;
        logic       po_mode;
        logic       pi_mode;
        // serial-code mode, stored only
        logic       scmode;
        // bit 4 write-empty, bit 3 read-full, bit 0 external request
        logic [4:0] ien;
        // live status, merged in on reads
        logic [4:0] status;
    } pioc_fields_t;

    // raw view for loads and reads, field view for decoding
    typedef union packed {
        pio_word_t    raw;
        pioc_fields_t f;
    } pioc_word_u;

    // both strobes active, shortest strobe, interrupts off
    localparam pioc_fields_t pioc_reset = '{
        stat_copy: 1'b0,
        stlen:     2'd0,
        po_mode:   1'b1,
        pi_mode:   1'b1,
        scmode:    1'b0,
        ien:       5'd0,
        status:    5'd0
    };

endpackage

// File: logic/pio_regfile.sv
// CPU side of the parallel I/O unit
// decodes register loads and reads, holds the control register
// and builds the word returned on the CPU read port
`timescale 1ns/1ns

module pio_regfile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic                   pio_imm_load,
    input  logic                   pio_ram_load,
    input  logic                   pio_acc_load,
    input  logic                   pdx_read,
    input  logic [1:0]             r_field,
    input  dsp_pio_pkg::pio_word_t long_imm,
    input  dsp_pio_pkg::pio_word_t ram_dout,
    input  dsp_pio_pkg::pio_word_t acc_dout,
    input  dsp_pio_pkg::pio_word_t pdx0_data,
    input  dsp_pio_pkg::pio_word_t pdx1_data,
    input  logic [4:0]             status_bits,
    output logic                   port_write,
    output logic                   port_read,
    output logic                   port_sel,
    output dsp_pio_pkg::pio_word_t port_wdata,
    output logic [1:0]             stlen,
    output logic                   ien_irq,
    output logic                   ien_siowr,
    output logic                   ien_siord,
    output dsp_pio_pkg::pio_word_t pio_dout
);

    dsp_pio_pkg::pio_addr_e  addr;
    dsp_pio_pkg::pioc_word_u pioc;
    dsp_pio_pkg::pioc_word_u imm_u;
    dsp_pio_pkg::pioc_word_u rd_u;
    logic                    any_load;
    logic                    is_pioc;
    logic                    ctrl_load;

    assign addr    = dsp_pio_pkg::pio_addr_e'(r_field);
    assign is_pioc = (addr == dsp_pio_pkg::pioc_addr);
    assign imm_u   = long_imm;

    // source priority: immediate, then RAM, then accumulator
    assign any_load   = pio_imm_load | pio_ram_load | pio_acc_load;
    assign port_wdata = pio_imm_load ? long_imm :
                        pio_ram_load ? ram_dout : acc_dout;

    // data register accesses go to the bus port as one-cycle pulses
    assign ctrl_load  = any_load & is_pioc;
    assign port_write = any_load & ~is_pioc;
    assign port_read  = pdx_read & ~is_pioc;
    // register 0 selects 0, anything else selects register 1
    assign port_sel   = (addr != dsp_pio_pkg::pdx0_addr);

    // control register, fields always come from the immediate bus
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pioc.f <= dsp_pio_pkg::pioc_reset;
        end else if (cen && ctrl_load) begin
            pioc.f.stlen   <= imm_u.f.stlen;
            pioc.f.po_mode <= imm_u.f.po_mode;
            pioc.f.pi_mode <= imm_u.f.pi_mode;
            pioc.f.scmode  <= imm_u.f.scmode;
            pioc.f.ien     <= imm_u.f.ien;
        end
    end

    // decoded controls for the other two blocks
    assign stlen     = pioc.f.stlen;
    assign ien_irq   = pioc.f.ien[0];
    assign ien_siord = pioc.f.ien[3];
    assign ien_siowr = pioc.f.ien[4];

    // control read: stored fields, live status, top bit copies status msb
    always_comb begin
        rd_u             = pioc;
        rd_u.f.status    = status_bits;
        rd_u.f.stat_copy = status_bits[4];
    end

    always_comb begin
        case (addr)
            dsp_pio_pkg::pioc_addr: pio_dout = rd_u.raw;
            dsp_pio_pkg::pdx0_addr: pio_dout = pdx0_data;
            default:                pio_dout = pdx1_data;
        endcase
    end

endmodule

// File: logic/pio_bus_port.sv
// external parallel bus in active mode
// a write drives the output word and pulses pods_n, a read pulses
// pids_n and captures pbus_in into the data register picked by psel
`timescale 1ns/1ns

module pio_bus_port (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic                   port_write,
    input  logic                   port_read,
    input  logic                   port_sel,
    input  dsp_pio_pkg::pio_word_t port_wdata,
    input  logic [1:0]             stlen,
    input  dsp_pio_pkg::pio_word_t pbus_in,
    output dsp_pio_pkg::pio_word_t pbus_out,
    output logic                   pods_n,
    output logic                   pids_n,
    output logic                   psel,
    output dsp_pio_pkg::pio_word_t pdx0_data,
    output dsp_pio_pkg::pio_word_t pdx1_data
);

    logic [3:0] pocnt;
    logic [3:0] picnt;
    logic [3:0] ststart;
    logic       in_last;

    // start pattern holds stlen+1 zeros at the bottom
    // shifting in ones from the top releases the strobe
    assign ststart = 4'he << stlen;

    assign pods_n = pocnt[0];
    assign pids_n = picnt[0];

    // last low cycle of the input strobe
    assign in_last = ~picnt[0] & picnt[1];

    // strobe counters, a new access restarts the count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pocnt <= 4'hf;
            picnt <= 4'hf;
        end else if (cen) begin
            pocnt <= port_write ? ststart : {1'b1, pocnt[3:1]};
            picnt <= port_read ? ststart : {1'b1, picnt[3:1]};
        end
    end

    // output word and peripheral select
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pbus_out <= '0;
            psel     <= 1'b0;
        end else if (cen) begin
            if (port_write || port_read) begin
                psel <= port_sel;
            end
            if (port_write) begin
                pbus_out <= port_wdata;
            end
        end
    end

    // input capture as the strobe ends
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pdx0_data <= '0;
            pdx1_data <= '0;
        end else if (cen && in_last) begin
            if (psel) begin
                pdx1_data <= pbus_in;
            end else begin
                pdx0_data <= pbus_in;
            end
        end
    end

endmodule

// File: logic/pio_irq_unit.sv
// interrupt latch of the parallel I/O unit
// sets on a rising edge of any enabled source, clears after the
// falling edge of iack, and reports the live status bits
`timescale 1ns/1ns

module pio_irq_unit (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       irq,
    input  logic       siord_full,
    input  logic       siowr_empty,
    input  logic       iack,
    input  logic       ien_irq,
    input  logic       ien_siowr,
    input  logic       ien_siord,
    output logic       irq_latch,
    output logic [4:0] status_bits
);

    logic irq_masked;
    logic last_irq;
    logic last_siord;
    logic last_siowr;
    logic last_iack;
    logic iack_fall;
    logic irq_rise;
    logic siord_rise;
    logic siowr_rise;
    logic set_latch;

    // external request is gated before edge detection
    assign irq_masked = irq & ien_irq;

    assign iack_fall  = ~iack & last_iack;
    assign irq_rise   = irq_masked & ~last_irq;
    assign siord_rise = siord_full & ~last_siord;
    assign siowr_rise = siowr_empty & ~last_siowr;

    // serial flags are masked after detection
    assign set_latch = irq_rise | (siord_rise & ien_siord) | (siowr_rise & ien_siowr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_irq   <= 1'b0;
            last_siord <= 1'b0;
            last_siowr <= 1'b0;
            last_iack  <= 1'b0;
            irq_latch  <= 1'b0;
        end else if (cen) begin
            last_iack  <= iack;
            // acknowledge forgets the request, a held line fires again
            last_irq   <= irq_masked & ~iack_fall;
            last_siord <= siord_full;
            last_siowr <= siowr_empty;
            // new edge wins over the clear
            if (set_latch) begin
                irq_latch <= 1'b1;
            end else if (iack_fall) begin
                irq_latch <= 1'b0;
            end
        end
    end

    // write-empty, read-full, two zeros, masked request
    assign status_bits = {siowr_empty, siord_full, 2'b00, irq_masked};

endmodule

// File: logic/dsp_pio_top.sv
// parallel I/O unit of the 16-bit DSP core, active mode only
// the register file decodes CPU accesses, the bus port drives the pins
// and the interrupt unit raises irq_latch
`timescale 1ns/1ns

module dsp_pio_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  dsp_pio_pkg::pio_word_t pbus_in,
    output dsp_pio_pkg::pio_word_t pbus_out,
    output logic                   pods_n,
    output logic                   pids_n,
    output logic                   psel,
    input  logic                   irq,
    input  logic                   pdx_read,
    input  logic                   pio_imm_load,
    input  logic                   pio_ram_load,
    input  logic                   pio_acc_load,
    input  logic [1:0]             r_field,
    output dsp_pio_pkg::pio_word_t pio_dout,
    input  dsp_pio_pkg::pio_word_t long_imm,
    input  dsp_pio_pkg::pio_word_t ram_dout,
    input  dsp_pio_pkg::pio_word_t acc_dout,
    input  logic                   siord_full,
    input  logic                   siowr_empty,
    input  logic                   iack,
    output logic                   irq_latch
);

    // register file to bus port
    logic                   port_write;
    logic                   port_read;
    logic                   port_sel;
    dsp_pio_pkg::pio_word_t port_wdata;
    logic [1:0]             stlen;
    // register file to interrupt unit
    logic                   ien_irq;
    logic                   ien_siowr;
    logic                   ien_siord;
    // back to the read mux
    dsp_pio_pkg::pio_word_t pdx0_data;
    dsp_pio_pkg::pio_word_t pdx1_data;
    logic [4:0]             status_bits;

    pio_regfile u_regfile (
        .clk          (clk),
        .rst          (rst),
        .cen          (cen),
        .pio_imm_load (pio_imm_load),
        .pio_ram_load (pio_ram_load),
        .pio_acc_load (pio_acc_load),
        .pdx_read     (pdx_read),
        .r_field      (r_field),
        .long_imm     (long_imm),
        .ram_dout     (ram_dout),
        .acc_dout     (acc_dout),
        .pdx0_data    (pdx0_data),
        .pdx1_data    (pdx1_data),
        .status_bits  (status_bits),
        .port_write   (port_write),
        .port_read    (port_read),
        .port_sel     (port_sel),
        .port_wdata   (port_wdata),
        .stlen        (stlen),
        .ien_irq      (ien_irq),
        .ien_siowr    (ien_siowr),
        .ien_siord    (ien_siord),
        .pio_dout     (pio_dout)
    );

    pio_bus_port u_bus_port (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .port_write (port_write),
        .port_read  (port_read),
        .port_sel   (port_sel),
        .port_wdata (port_wdata),
        .stlen      (stlen),
        .pbus_in    (pbus_in),
        .pbus_out   (pbus_out),
        .pods_n     (pods_n),
        .pids_n     (pids_n),
        .psel       (psel),
        .pdx0_data  (pdx0_data),
        .pdx1_data  (pdx1_data)
    );

    pio_irq_unit u_irq_unit (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .irq         (irq),
        .siord_full  (siord_full),
        .siowr_empty (siowr_empty),
        .iack        (iack),
        .ien_irq     (ien_irq),
        .ien_siowr   (ien_siowr),
        .ien_siord   (ien_siord),
        .irq_latch   (irq_latch),
        .status_bits (status_bits)
    );

endmodule

// File: verif/tb_pio_model.svh
// reference model of the parallel I/O unit, included in the testbench module
// model_step advances the state on one clock edge from the inputs seen
// before that edge, expect_dout gives the word on the CPU read port

// control word as loaded, status bits are not stored
dsp_pio_pkg::pio_word_t m_ctrl;
dsp_pio_pkg::pio_word_t m_pbus_out;
dsp_pio_pkg::pio_word_t m_pdx0;
dsp_pio_pkg::pio_word_t m_pdx1;
logic                   m_psel;
logic                   m_latch;
// enabled clocks left with the strobe low
int                     m_ocnt;
int                     m_icnt;
logic                   m_prev_irq;
logic                   m_prev_siord;
logic                   m_prev_siowr;
logic                   m_prev_iack;

task automatic model_reset();
    m_ctrl       = dsp_pio_pkg::pioc_reset;
    m_pbus_out   = '0;
    m_pdx0       = '0;
    m_pdx1       = '0;
    m_psel       = 1'b0;
    m_latch      = 1'b0;
    m_ocnt       = 0;
    m_icnt       = 0;
    m_prev_irq   = 1'b0;
    m_prev_siord = 1'b0;
    m_prev_siowr = 1'b0;
    m_prev_iack  = 1'b0;
endtask

// write-empty, read-full, two zeros, request behind its enable
function automatic logic [4:0] model_status();
    return {siowr_empty, siord_full, 2'b00, irq & m_ctrl[5]};
endfunction

function automatic dsp_pio_pkg::pio_word_t expect_dout();
    logic [4:0] st;
    st = model_status();
    if (r_field == dsp_pio_pkg::pioc_addr) begin
        return {st[4], m_ctrl[14:5], st};
    end
    if (r_field == dsp_pio_pkg::pdx0_addr) begin
        return m_pdx0;
    end
    return m_pdx1;
endfunction

task automatic model_step();
    logic                   load;
    logic                   fall;
    logic                   hit;
    logic [4:0]             st;
    dsp_pio_pkg::pio_word_t word;
    // a disabled clock leaves everything as it was
    if (!cen) begin
        return;
    end
    load = pio_imm_load | pio_ram_load | pio_acc_load;
    word = pio_imm_load ? long_imm : (pio_ram_load ? ram_dout : acc_dout);
    st   = model_status();
    fall = m_prev_iack & ~iack;
    // ien bit 0 external, bit 3 read-full, bit 4 write-empty
    hit  = (st[0] & ~m_prev_irq) | (m_ctrl[8] & siord_full & ~m_prev_siord) |
           (m_ctrl[9] & siowr_empty & ~m_prev_siowr);
    if (hit) begin
        m_latch = 1'b1;
    end else if (fall) begin
        m_latch = 1'b0;
    end
    // acknowledge forgets the external request
    m_prev_irq   = st[0] & ~fall;
    m_prev_siord = siord_full;
    m_prev_siowr = siowr_empty;
    m_prev_iack  = iack;
    // capture as the last low input strobe cycle ends
    if (m_icnt == 1) begin
        if (m_psel) begin
            m_pdx1 = pbus_in;
        end else begin
            m_pdx0 = pbus_in;
        end
    end
    m_ocnt = (m_ocnt > 0) ? m_ocnt - 1 : 0;
    m_icnt = (m_icnt > 0) ? m_icnt - 1 : 0;
    if (r_field == dsp_pio_pkg::pioc_addr) begin
        // control fields always come from the immediate bus
        if (load) begin
            m_ctrl[14:5] = long_imm[14:5];
        end
    end else begin
        if (load) begin
            m_ocnt     = m_ctrl[14:13] + 1;
            m_pbus_out = word;
        end
        if (pdx_read) begin
            m_icnt = m_ctrl[14:13] + 1;
        end
        if (load || pdx_read) begin
            m_psel = (r_field != dsp_pio_pkg::pdx0_addr);
        end
    end
endtask

// File: verif/tb_dsp_pio.sv
// testbench for the parallel I/O unit
// directed tests and a long random mix, every cycle checked
// against the reference model from tb_pio_model.svh
`timescale 1ns/1ns

module tb_dsp_pio;

    logic                   clk;
    logic                   rst;
    logic                   cen;
    dsp_pio_pkg::pio_word_t pbus_in;
    dsp_pio_pkg::pio_word_t pbus_out;
    logic                   pods_n;
    logic                   pids_n;
    logic                   psel;
    logic                   irq;
    logic                   pdx_read;
    logic                   pio_imm_load;
    logic                   pio_ram_load;
    logic                   pio_acc_load;
    logic [1:0]             r_field;
    dsp_pio_pkg::pio_word_t pio_dout;
    dsp_pio_pkg::pio_word_t long_imm;
    dsp_pio_pkg::pio_word_t ram_dout;
    dsp_pio_pkg::pio_word_t acc_dout;
    logic                   siord_full;
    logic                   siowr_empty;
    logic                   iack;
    logic                   irq_latch;

    // values put on the pins at the next rising edge
    logic                   irq_s = 1'b0;
    logic                   siord_s = 1'b0;
    logic                   siowr_s = 1'b0;
    logic                   iack_s = 1'b0;
    dsp_pio_pkg::pio_word_t imm_s = '0;
    dsp_pio_pkg::pio_word_t pin_s = '0;
    // word that the last load carried, priority applied
    dsp_pio_pkg::pio_word_t last_word;
    string                  test_name;
    int                     test_errs = 0;
    int                     total_errs = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;

    `include "tb_pio_model.svh"

    dsp_pio_top u_dsp_pio_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_word(input string what, input dsp_pio_pkg::pio_word_t exp,
                              input dsp_pio_pkg::pio_word_t act);
        if (act !== exp) begin
            test_errs++;
            if (test_errs <= 8) begin
                $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
            end
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            test_errs++;
            if (test_errs <= 8) begin
                $display("** Error %s %s: expected %b, actual %b", test_name, what, exp, act);
            end
        end
    endtask

    task automatic check_outputs();
        check_word("pio_dout", expect_dout(), pio_dout);
        check_word("pbus_out", m_pbus_out, pbus_out);
        check_bit("pods_n", m_ocnt == 0, pods_n);
        check_bit("pids_n", m_icnt == 0, pids_n);
        check_bit("psel", m_psel, psel);
        check_bit("irq_latch", m_latch, irq_latch);
    endtask

    // one clock: model takes the edge, next inputs go out, outputs checked at the fall
    // ops bit 3 immediate load, bit 2 RAM load, bit 1 accumulator load, bit 0 read
    task automatic cycle(input logic [3:0] ops, input logic [1:0] addr, input logic en_hi);
        dsp_pio_pkg::pio_word_t ram_w;
        dsp_pio_pkg::pio_word_t acc_w;
        @(posedge clk);
        model_step();
        ram_w        = 16'($urandom);
        acc_w        = 16'($urandom);
        last_word    = ops[3] ? imm_s : (ops[2] ? ram_w : acc_w);
        cen          <= en_hi | ($urandom % 4 != 0);
        pio_imm_load <= ops[3];
        pio_ram_load <= ops[2];
        pio_acc_load <= ops[1];
        pdx_read     <= ops[0];
        r_field      <= addr;
        long_imm     <= imm_s;
        ram_dout     <= ram_w;
        acc_dout     <= acc_w;
        pbus_in      <= pin_s;
        irq          <= irq_s;
        siord_full   <= siord_s;
        siowr_empty  <= siowr_s;
        iack         <= iack_s;
        @(negedge clk);
        check_outputs();
    endtask

    // enabled clocks that a strobe stays low after the access cycle
    task automatic measure_strobe(input logic in_side, input logic [1:0] addr,
                                  output int width);
        int   guard;
        logic strobe;
        width = 0;
        guard = 0;
        do begin
            cycle(4'b0000, addr, 1'b0);
            strobe = in_side ? pids_n : pods_n;
            if (!strobe && cen) begin
                width++;
            end
            guard++;
        end while (!strobe && guard < 64);
        if (!strobe) begin
            $display("%s: timeout, strobe still low after %0d clocks", test_name, guard);
            test_errs++;
        end
    endtask

    task automatic wait_latch();
        int guard;
        guard = 0;
        while (irq_latch !== 1'b1 && guard < 32) begin
            cycle(4'b0000, 2'd0, 1'b0);
            guard++;
        end
        if (irq_latch !== 1'b1) begin
            $display("%s: timeout, irq_latch never rose", test_name);
            test_errs++;
        end
    endtask

    // iack high then low, the fall clears the latch
    task automatic ack_pulse();
        iack_s = 1'b1;
        cycle(4'b0000, 2'd0, 1'b1);
        iack_s = 1'b0;
        cycle(4'b0000, 2'd0, 1'b1);
        cycle(4'b0000, 2'd0, 1'b1);
    endtask

    // random control word with stlen kept, interrupts masked
    task automatic load_ctrl(output logic [1:0] sl);
        imm_s      = 16'($urandom);
        imm_s[9:5] = 5'd0;
        sl         = imm_s[14:13];
        cycle(4'b1000, 2'd0, 1'b1);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("%-12s ok", test_name);
        end else begin
            tests_failed++;
            $display("%-12s %0d errors", test_name, test_errs);
        end
    endtask

    initial begin
        int                     width;
        int                     src;
        logic                   en;
        logic [1:0]             sl;
        logic [1:0]             addr;
        logic [3:0]             ops;
        logic [4:0]             st;
        dsp_pio_pkg::pio_word_t word;
        void'($urandom(86270));
        rst          <= 1'b1;
        cen          <= 1'b0;
        pbus_in      <= '0;
        irq          <= 1'b0;
        pdx_read     <= 1'b0;
        pio_imm_load <= 1'b0;
        pio_ram_load <= 1'b0;
        pio_acc_load <= 1'b0;
        r_field      <= 2'd0;
        long_imm     <= '0;
        ram_dout     <= '0;
        acc_dout     <= '0;
        siord_full   <= 1'b0;
        siowr_empty  <= 1'b0;
        iack         <= 1'b0;
        model_reset();
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        begin_test("reset");
        @(negedge clk);
        check_bit("pods_n", 1'b1, pods_n);
        check_bit("pids_n", 1'b1, pids_n);
        check_bit("psel", 1'b0, psel);
        check_bit("irq_latch", 1'b0, irq_latch);
        // stlen 0, both modes active, scmode and enables off, no status
        check_word("pioc", {1'b0, 2'd0, 1'b1, 1'b1, 1'b0, 5'd0, 5'd0}, pio_dout);
        end_test();

        // any load source, the fields still come from the immediate bus
        begin_test("pioc load");
        for (int k = 0; k < 24; k++) begin
            imm_s   = 16'($urandom);
            irq_s   = 1'($urandom);
            siord_s = 1'($urandom);
            siowr_s = 1'($urandom);
            cycle(4'b1000 >> ($urandom % 3), 2'd0, 1'b1);
            cycle(4'b0000, 2'd0, 1'b0);
            st = {siowr_s, siord_s, 2'b00, irq_s & imm_s[5]};
            check_word("readback", {st[4], imm_s[14:5], st}, pio_dout);
            ack_pulse();
        end
        irq_s   = 1'b0;
        siord_s = 1'b0;
        siowr_s = 1'b0;
        end_test();

        begin_test("data load");
        for (int k = 0; k < 18; k++) begin
            load_ctrl(sl);
            addr = 2'(1 + $urandom % 2);
            cycle(4'b1000 >> (k % 3), addr, 1'b1);
            word = last_word;
            measure_strobe(1'b0, addr, width);
            check_word("pbus_out", word, pbus_out);
            check_bit("psel", addr != 2'd1, psel);
            check_word("pods_n width", 16'(sl + 1), 16'(width));
        end
        end_test();

        begin_test("data read");
        for (int k = 0; k < 18; k++) begin
            load_ctrl(sl);
            addr  = 2'(1 + $urandom % 3);
            pin_s = 16'($urandom);
            cycle(4'b0001, addr, 1'b1);
            measure_strobe(1'b1, addr, width);
            check_bit("psel", addr != 2'd1, psel);
            check_word("pids_n width", 16'(sl + 1), 16'(width));
            check_word("readback", pin_s, pio_dout);
        end
        end_test();

        begin_test("interrupts");
        for (int k = 0; k < 24; k++) begin
            src        = $urandom % 3;
            en         = 1'($urandom);
            imm_s      = 16'($urandom);
            imm_s[9:5] = 5'd0;
            // enable of the chosen source only
            if (src == 0) imm_s[5] = en;
            else if (src == 1) imm_s[8] = en;
            else imm_s[9] = en;
            cycle(4'b1000, 2'd0, 1'b1);
            ack_pulse();
            check_bit("cleared", 1'b0, irq_latch);
            irq_s   = (src == 0);
            siord_s = (src == 1);
            siowr_s = (src == 2);
            if (en) begin
                wait_latch();
            end else begin
                repeat (6) cycle(4'b0000, 2'd0, 1'b0);
                check_bit("disabled", 1'b0, irq_latch);
            end
            st = {siowr_s, siord_s, 2'b00, irq_s & en};
            check_word("status", {11'd0, st}, {11'd0, pio_dout[4:0]});
            irq_s   = 1'b0;
            siord_s = 1'b0;
            siowr_s = 1'b0;
            cycle(4'b0000, 2'd0, 1'b1);
            ack_pulse();
            check_bit("ack clear", 1'b0, irq_latch);
        end
        end_test();

        // accesses, bus data and interrupt lines all random
        begin_test("random mix");
        for (int k = 0; k < 4000; k++) begin
            imm_s = 16'($urandom);
            pin_s = 16'($urandom);
            if ($urandom % 8 == 0) irq_s = ~irq_s;
            if ($urandom % 8 == 0) siord_s = ~siord_s;
            if ($urandom % 8 == 0) siowr_s = ~siowr_s;
            if ($urandom % 6 == 0) iack_s = ~iack_s;
            ops = ($urandom % 3 == 0) ? 4'($urandom) : 4'b0000;
            cycle(ops, 2'($urandom), 1'b0);
        end
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+verif
logic/dsp_pio_pkg.sv
logic/pio_regfile.sv
logic/pio_bus_port.sv
logic/pio_irq_unit.sv
logic/dsp_pio_top.sv
verif/tb_dsp_pio.sv

// File: run_sim.sh
#!/bin/sh
# build the parallel I/O testbench with Verilator and run it
# the result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_dsp_pio -o tb_dsp_pio_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_dsp_pio_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0
